// File: Makefile
# Verilator build and run for the cu_dp_mem testbench

VERILATOR ?= verilator
TOP       ?= tb_cu_dp_mem
LOG       ?= sim.log
SEED      ?= 210101208
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP LOG SEED OBJ_DIR FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
logic/isa_pkg.sv
logic/mem_pkg.sv
logic/instr_decoder.sv
logic/exec_unit.sv
logic/result_commit.sv
logic/cu_dp_mem.sv
sim/cu_dp_mem_chk.sv
sim/tb_cu_dp_mem.sv

// File: logic/cu_dp_mem.sv
// No fetch or PC; instructions come from outside and must be held while stall_o is high
`timescale 1ns/1ps
`default_nettype none

module cu_dp_mem
	import isa_pkg::*;
	import mem_pkg::*;
#(
	parameter int REG_COUNT = 32
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic [ILEN-1:0]        ins_i,
	input  logic                   ins_valid_i,
	output logic                   stall_o,
	// L2 port
	output l2_req_t                l2_req_o,
	input  logic                   l2_req_rdy_i,
	input  l2_ans_t                l2_ans_i,
	output logic                   l2_ans_rdy_o,
	// Commit and exception reporting
	output logic                   commit_valid_o,
	output logic [REG_IDX_LEN-1:0] commit_rd_o,
	output logic [XLEN-1:0]        commit_data_o,
	output logic                   except_raised_o,
	output except_code_e           except_code_o,
	output logic [15:0]            commit_cnt_o
);

	decoded_instr_t dec;
	commit_t res;
	logic [REG_IDX_LEN-1:0] rs1_idx;
	logic [REG_IDX_LEN-1:0] rs2_idx;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic flush;

	instr_decoder #(
		.REG_COUNT (REG_COUNT)
	) u_instr_decoder (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.ins_i       (ins_i),
		.ins_valid_i (ins_valid_i),
		.stall_i     (stall_o),
		.flush_i     (flush),
		.dec_o       (dec)
	);

	exec_unit u_exec_unit (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.dec_i        (dec),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.rs1_idx_o    (rs1_idx),
		.rs2_idx_o    (rs2_idx),
		.stall_o      (stall_o),
		.res_o        (res),
		.l2_req_o     (l2_req_o),
		.l2_req_rdy_i (l2_req_rdy_i),
		.l2_ans_i     (l2_ans_i),
		.l2_ans_rdy_o (l2_ans_rdy_o)
	);

	result_commit #(
		.REG_COUNT (REG_COUNT)
	) u_result_commit (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.res_i           (res),
		.rs1_idx_i       (rs1_idx),
		.rs2_idx_i       (rs2_idx),
		.rs1_data_o      (rs1_data),
		.rs2_data_o      (rs2_data),
		.flush_o         (flush),
		.commit_valid_o  (commit_valid_o),
		.commit_rd_o     (commit_rd_o),
		.commit_data_o   (commit_data_o),
		.except_raised_o (except_raised_o),
		.except_code_o   (except_code_o),
		.commit_cnt_o    (commit_cnt_o)
	);

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
// One memory operation at a time; stall_o stays high until its L2 answer arrives
`timescale 1ns/1ps
`default_nettype none

module exec_unit
	import isa_pkg::*;
	import mem_pkg::*;
(
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  decoded_instr_t         dec_i,
	input  logic [XLEN-1:0]        rs1_data_i,
	input  logic [XLEN-1:0]        rs2_data_i,
	output logic [REG_IDX_LEN-1:0] rs1_idx_o,
	output logic [REG_IDX_LEN-1:0] rs2_idx_o,
	output logic                   stall_o,
	output commit_t                res_o,
	output l2_req_t                l2_req_o,
	input  logic                   l2_req_rdy_i,
	input  l2_ans_t                l2_ans_i,
	output logic                   l2_ans_rdy_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_ANS
	} state_e;

	state_e state_q;
	l2_req_t req_q;
	logic fwd_rs1;
	logic fwd_rs2;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] eff_addr;
	logic misaligned;

	// Register file read ports
	assign rs1_idx_o = dec_i.rs1;
	assign rs2_idx_o = dec_i.rs2;

	// Bypass the result not yet written back
	assign fwd_rs1 = res_o.valid && res_o.writes_rd && res_o.rd == dec_i.rs1 && dec_i.rs1 != '0;
	assign fwd_rs2 = res_o.valid && res_o.writes_rd && res_o.rd == dec_i.rs2 && dec_i.rs2 != '0;
	assign op_a = fwd_rs1 ? res_o.data : rs1_data_i;
	assign rs2_val = fwd_rs2 ? res_o.data : rs2_data_i;

	// x0 in rs2 selects the immediate
	assign op_b = (dec_i.rs2 == '0) ? dec_i.imm : rs2_val;
	assign alu_res = (dec_i.op == OP_SUB) ? op_a - op_b : op_a + op_b;

	// Word accesses only
	assign eff_addr = op_a + dec_i.imm;
	assign misaligned = eff_addr[1:0] != 2'b00;

	assign stall_o = state_q != S_IDLE;
	assign l2_req_o = req_q;
	assign l2_ans_rdy_o = state_q == S_ANS;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= S_IDLE;
			req_q.valid <= 1'b0;
			res_o.valid <= 1'b0;
			res_o.except_raised <= 1'b0;
		end else begin
			// Single-cycle pulses
			res_o.valid <= 1'b0;
			res_o.except_raised <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (dec_i.valid) begin
						// rd kept through a memory access
						res_o.rd <= dec_i.rd;
						res_o.writes_rd <= dec_i.writes_rd;
						if (dec_i.illegal) begin
							res_o.except_raised <= 1'b1;
							res_o.except_code <= EXC_ILLEGAL_INSTR;
						end else if (dec_i.op == OP_LOAD || dec_i.op == OP_STORE) begin
							if (misaligned) begin
								// No L2 traffic
								res_o.except_raised <= 1'b1;
								res_o.except_code <= (dec_i.op == OP_LOAD) ?
									EXC_LD_MISALIGNED : EXC_ST_MISALIGNED;
							end else begin
								req_q.valid <= 1'b1;
								req_q.op <= (dec_i.op == OP_LOAD) ? MEM_READ : MEM_WRITE;
								req_q.addr <= eff_addr[XLEN-1:2];
								req_q.wdata <= rs2_val;
								state_q <= S_REQ;
							end
						end else begin
							res_o.valid <= 1'b1;
							res_o.data <= alu_res;
						end
					end
				end
				S_REQ: begin
					// Fields held until the L2 takes the request
					if (l2_req_rdy_i) begin
						req_q.valid <= 1'b0;
						state_q <= S_ANS;
					end
				end
				S_ANS: begin
					if (l2_ans_i.valid) begin
						res_o.valid <= 1'b1;
						// Store completes with zero data
						res_o.data <= (req_q.op == MEM_READ) ? l2_ans_i.rdata : '0;
						state_q <= S_IDLE;
					end
				end
				default: begin
					state_q <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/instr_decoder.sv
// Source must hold ins_i while stall_i is high; REG_COUNT must be 16 or 32
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
	import isa_pkg::*;
#(
	parameter int REG_COUNT = 32
) (
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic [ILEN-1:0] ins_i,
	input  logic            ins_valid_i,
	input  logic            stall_i,
	input  logic            flush_i,
	output decoded_instr_t  dec_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [REG_IDX_LEN-1:0] rd;
	logic [REG_IDX_LEN-1:0] rs1;
	logic [REG_IDX_LEN-1:0] rs2;
	logic rd_bad;
	logic rs1_bad;
	logic rs2_bad;
	decoded_instr_t dec_d;
	decoded_instr_t dec_q;

	// Instruction fields
	assign opcode = ins_i[6:0];
	assign rd = ins_i[11:7];
	assign funct3 = ins_i[14:12];
	assign rs1 = ins_i[19:15];
	assign rs2 = ins_i[24:20];
	assign funct7 = ins_i[31:25];

	// Indices past the end of an E register file
	assign rd_bad = int'(rd) >= REG_COUNT;
	assign rs1_bad = int'(rs1) >= REG_COUNT;
	assign rs2_bad = int'(rs2) >= REG_COUNT;

	// I-type decodes rs2 as x0 and R-type carries a zero immediate
	always_comb begin
		dec_d = '0;
		dec_d.valid = ins_valid_i;
		dec_d.op = OP_NONE;
		dec_d.rs1 = rs1;
		case (opcode)
			OPCODE_OP: begin
				dec_d.rd = rd;
				dec_d.rs2 = rs2;
				dec_d.writes_rd = 1'b1;
				dec_d.illegal = rd_bad | rs1_bad | rs2_bad;
				if (funct3 == FUNCT3_ADD_SUB && funct7 == FUNCT7_ADD) begin
					dec_d.op = OP_ADD;
				end else if (funct3 == FUNCT3_ADD_SUB && funct7 == FUNCT7_SUB) begin
					dec_d.op = OP_SUB;
				end
			end
			OPCODE_OP_IMM, OPCODE_LOAD: begin
				dec_d.rd = rd;
				dec_d.imm = {{20{ins_i[31]}}, ins_i[31:20]};
				dec_d.writes_rd = 1'b1;
				dec_d.illegal = rd_bad | rs1_bad;
				if (opcode == OPCODE_OP_IMM && funct3 == FUNCT3_ADD_SUB) begin
					dec_d.op = OP_ADD;
				end else if (opcode == OPCODE_LOAD && funct3 == FUNCT3_WORD) begin
					dec_d.op = OP_LOAD;
				end
			end
			OPCODE_STORE: begin
				// Store data in rs2, split offset
				dec_d.rs2 = rs2;
				dec_d.imm = {{20{ins_i[31]}}, ins_i[31:25], ins_i[11:7]};
				dec_d.illegal = rs1_bad | rs2_bad;
				if (funct3 == FUNCT3_WORD) begin
					dec_d.op = OP_STORE;
				end
			end
			default: begin
				dec_d.op = OP_NONE;
			end
		endcase
		// Unmatched opcode or funct
		if (dec_d.op == OP_NONE) begin
			dec_d.illegal = 1'b1;
		end
		dec_d.writes_rd = dec_d.writes_rd & ~dec_d.illegal;
	end

	// Hold under stall; a flush only comes with execute idle, so the next load replaces it
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			dec_q.valid <= 1'b0;
		end else if (!stall_i) begin
			dec_q <= dec_d;
		end
	end

	// Younger entry already invisible in the flush cycle
	always_comb begin
		dec_o = dec_q;
		dec_o.valid = dec_q.valid & ~flush_i;
	end

endmodule

`default_nettype wire

// File: logic/isa_pkg.sv
// Covers ADD, SUB, ADDI, LW and SW only; word accesses; no CSR, privilege or branch support
`default_nettype none

package isa_pkg;

	// Datapath and encoding widths
	localparam int XLEN = 32;
	localparam int ILEN = 32;
	localparam int REG_IDX_LEN = 5;

	// Major opcodes in bits 6 to 0
	localparam logic [6:0] OPCODE_OP = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPCODE_LOAD = 7'b0000011;
	localparam logic [6:0] OPCODE_STORE = 7'b0100011;

	// Function fields of the subset
	localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
	localparam logic [2:0] FUNCT3_WORD = 3'b010;
	localparam logic [6:0] FUNCT7_ADD = 7'b0000000;
	localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

	// Operation kinds seen by execute
	typedef enum logic [2:0] {
		OP_NONE,
		OP_ADD,
		OP_SUB,
		OP_LOAD,
		OP_STORE
	} op_e;

	// Same numbers as the mcause exception codes
	typedef enum logic [3:0] {
		EXC_ILLEGAL_INSTR = 4'd2,
		EXC_LD_MISALIGNED = 4'd4,
		EXC_ST_MISALIGNED = 4'd6
	} except_code_e;

	// Decode to execute
	typedef struct packed {
		logic valid;
		op_e op;
		logic [REG_IDX_LEN-1:0] rd;
		logic [REG_IDX_LEN-1:0] rs1;
		logic [REG_IDX_LEN-1:0] rs2;
		logic [XLEN-1:0] imm;
		logic writes_rd;
		logic illegal;
	} decoded_instr_t;

	// Execute to result stage
	typedef struct packed {
		logic valid;
		logic [REG_IDX_LEN-1:0] rd;
		logic [XLEN-1:0] data;
		logic writes_rd;
		logic except_raised;
		except_code_e except_code;
	} commit_t;

endpackage

`default_nettype wire

// File: logic/mem_pkg.sv
// L2 port carries whole words only, addresses are word indices, one operation outstanding
`default_nettype none

package mem_pkg;

	import isa_pkg::*;

	// Byte offset bits dropped from the address
	localparam int L2_ADDR_LEN = XLEN - 2;

	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_op_e;

	// Request toward the L2, fields stable until taken
	typedef struct packed {
		logic valid;
		mem_op_e op;
		logic [L2_ADDR_LEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} l2_req_t;

	// Answer from the L2
	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] rdata;
	} l2_ans_t;

endpackage

`default_nettype wire

// File: logic/result_commit.sv
// REG_COUNT must be a power of two; x0 is hardwired to zero and never stored
`timescale 1ns/1ps
`default_nettype none

module result_commit
	import isa_pkg::*;
#(
	parameter int REG_COUNT = 32
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  commit_t                res_i,
	input  logic [REG_IDX_LEN-1:0] rs1_idx_i,
	input  logic [REG_IDX_LEN-1:0] rs2_idx_i,
	output logic [XLEN-1:0]        rs1_data_o,
	output logic [XLEN-1:0]        rs2_data_o,
	output logic                   flush_o,
	output logic                   commit_valid_o,
	output logic [REG_IDX_LEN-1:0] commit_rd_o,
	output logic [XLEN-1:0]        commit_data_o,
	output logic                   except_raised_o,
	output except_code_e           except_code_o,
	output logic [15:0]            commit_cnt_o
);

	localparam int IDX_W = $clog2(REG_COUNT);

	logic [XLEN-1:0] rf [REG_COUNT];
	logic rs1_ok;
	logic rs2_ok;

	// Read as zero for x0 and out-of-range indices
	assign rs1_ok = rs1_idx_i != '0 && int'(rs1_idx_i) < REG_COUNT;
	assign rs2_ok = rs2_idx_i != '0 && int'(rs2_idx_i) < REG_COUNT;
	assign rs1_data_o = rs1_ok ? rf[rs1_idx_i[IDX_W-1:0]] : '0;
	assign rs2_data_o = rs2_ok ? rf[rs2_idx_i[IDX_W-1:0]] : '0;

	// Clears the younger instruction in decode
	assign flush_o = res_i.except_raised;

	// Write port
	always_ff @(posedge clk_i) begin
		if (res_i.valid && res_i.writes_rd && res_i.rd != '0) begin
			rf[res_i.rd[IDX_W-1:0]] <= res_i.data;
		end
	end

	// Strobes and the wrapping commit counter
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			commit_valid_o <= 1'b0;
			except_raised_o <= 1'b0;
			commit_cnt_o <= '0;
		end else begin
			commit_valid_o <= res_i.valid;
			except_raised_o <= res_i.except_raised;
			if (res_i.valid) begin
				commit_cnt_o <= commit_cnt_o + 16'd1;
			end
		end
	end

	// Reported data is zero for x0 writes
	always_ff @(posedge clk_i) begin
		commit_rd_o <= res_i.rd;
		commit_data_o <= (res_i.rd == '0) ? '0 : res_i.data;
		except_code_o <= res_i.except_code;
	end

endmodule

`default_nettype wire

// File: sim/cu_dp_mem_chk.sv
// Bound into cu_dp_mem; ALU timing is checked from the cycle an instruction enters execute
`timescale 1ns/1ps
`default_nettype none

module cu_dp_mem_chk
	import isa_pkg::*;
	import mem_pkg::*;
(
	input logic           clk_i,
	input logic           rst_i,
	input logic           stall_i,
	input decoded_instr_t dec_i,
	input l2_req_t        l2_req_i,
	input logic           l2_req_rdy_i,
	input l2_ans_t        l2_ans_i,
	input logic           l2_ans_rdy_i,
	input logic           commit_valid_i,
	input logic           except_raised_i
);

	logic outstanding;

	// Request taken, answer not yet taken
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			outstanding <= 1'b0;
		end else if (l2_req_i.valid && l2_req_rdy_i) begin
			outstanding <= 1'b1;
		end else if (l2_ans_i.valid && l2_ans_rdy_i) begin
			outstanding <= 1'b0;
		end
	end

	req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		l2_req_i.valid && !l2_req_rdy_i |=> $stable(l2_req_i))
		else $error("L2 request changed before it was taken");

	ans_rdy_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
		l2_ans_rdy_i |-> outstanding)
		else $error("answer ready with no request outstanding");

	commit_except_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		!(commit_valid_i && except_raised_i))
		else $error("commit and exception in the same cycle");

	// Legal ALU op in an idle execute stage
	alu_latency: assert property (@(posedge clk_i) disable iff (rst_i)
		dec_i.valid && !stall_i && !dec_i.illegal && (dec_i.op == OP_ADD || dec_i.op == OP_SUB)
		|-> ##2 commit_valid_i)
		else $error("ALU instruction did not commit two cycles after execute");

endmodule

bind cu_dp_mem cu_dp_mem_chk u_cu_dp_mem_chk (
	.clk_i           (clk_i),
	.rst_i           (rst_i),
	.stall_i         (stall_o),
	.dec_i           (dec),
	.l2_req_i        (l2_req_o),
	.l2_req_rdy_i    (l2_req_rdy_i),
	.l2_ans_i        (l2_ans_i),
	.l2_ans_rdy_i    (l2_ans_rdy_o),
	.commit_valid_i  (commit_valid_o),
	.except_raised_i (except_raised_o)
);

`default_nettype wire

// File: sim/tb_cu_dp_mem.sv
// Runs the DUT with REG_COUNT 16; L2 model holds 256 words indexed by the low address bits
`timescale 1ns/1ps
`default_nettype none

module tb_cu_dp_mem
	import isa_pkg::*;
	import mem_pkg::*;
#(
	parameter int SEED = 32'h0c85e3d8
);

	localparam logic [1:0] K_COMMIT = 2'd0;
	localparam logic [1:0] K_EXCEPT = 2'd1;
	localparam logic [1:0] K_FLUSH = 2'd2;

	typedef struct packed {
		logic [31:0] ins;
		logic [1:0] kind;
		logic [4:0] rd;
		logic [31:0] data;
		logic [3:0] code;
		logic l2;
		logic chk_mem;
		logic [7:0] mem_idx;
	} entry_t;

	logic clk_i;
	logic rst_i;
	logic [31:0] ins_i;
	logic ins_valid_i;
	logic stall_o;
	l2_req_t l2_req_o;
	logic l2_req_rdy_i;
	l2_ans_t l2_ans_i;
	logic l2_ans_rdy_o;
	logic commit_valid_o;
	logic [4:0] commit_rd_o;
	logic [31:0] commit_data_o;
	logic except_raised_o;
	except_code_e except_code_o;
	logic [15:0] commit_cnt_o;

	entry_t tbl [$];
	entry_t exp_q [$];
	logic [31:0] mem [256];
	integer seed;
	int cycles;
	int limit;
	int req_cnt;
	logic pending;
	logic [1:0] req_wait;
	logic [1:0] ans_wait;
	logic [31:0] ans_data;

	cu_dp_mem #(
		.REG_COUNT (16)
	) u_cu_dp_mem (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.ins_i           (ins_i),
		.ins_valid_i     (ins_valid_i),
		.stall_o         (stall_o),
		.l2_req_o        (l2_req_o),
		.l2_req_rdy_i    (l2_req_rdy_i),
		.l2_ans_i        (l2_ans_i),
		.l2_ans_rdy_o    (l2_ans_rdy_o),
		.commit_valid_o  (commit_valid_o),
		.commit_rd_o     (commit_rd_o),
		.commit_data_o   (commit_data_o),
		.except_raised_o (except_raised_o),
		.except_code_o   (except_code_o),
		.commit_cnt_o    (commit_cnt_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_equal(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, what, got, want));
		end
	endtask

	// Instruction encoders
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [4:0] rd);
		return {f7, rs2, rs1, 3'b000, rd, 7'h33};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
	endfunction

	task automatic add_commit(input logic [31:0] ins, input logic [4:0] rd, input logic [31:0] data);
		tbl.push_back(entry_t'{ins, K_COMMIT, rd, data, 4'd0, ins[6:0] == 7'h03, 1'b0, 8'd0});
	endtask

	// Store commits report rd 0 and data 0
	task automatic add_store(input logic [31:0] ins, input logic [7:0] idx, input logic [31:0] val);
		tbl.push_back(entry_t'{ins, K_COMMIT, 5'd0, val, 4'd0, 1'b1, 1'b1, idx});
	endtask

	task automatic add_except(input logic [31:0] ins, input logic [3:0] code);
		tbl.push_back(entry_t'{ins, K_EXCEPT, 5'd0, 32'd0, code, 1'b0, 1'b0, 8'd0});
	endtask

	task automatic add_flush(input logic [31:0] ins);
		tbl.push_back(entry_t'{ins, K_FLUSH, 5'd0, 32'd0, 4'd0, 1'b0, 1'b0, 8'd0});
	endtask

	task automatic build_table();
		// Dependent ALU chain with forwarding and wraparound
		add_commit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'h13), 5'd1, 32'd5);
		add_commit(enc_i(12'hffd, 5'd1, 3'd0, 5'd2, 7'h13), 5'd2, 32'd2);
		add_commit(enc_r(7'h00, 5'd2, 5'd1, 5'd3), 5'd3, 32'd7);
		add_commit(enc_r(7'h20, 5'd1, 5'd3, 5'd4), 5'd4, 32'd2);
		add_commit(enc_r(7'h20, 5'd3, 5'd0, 5'd5), 5'd5, 32'hffff_fff9);
		add_commit(enc_i(12'h7ff, 5'd5, 3'd0, 5'd6, 7'h13), 5'd6, 32'h0000_07f8);
		add_commit(enc_r(7'h00, 5'd5, 5'd5, 5'd7), 5'd7, 32'hffff_fff2);
		add_commit(enc_i(12'hfff, 5'd0, 3'd0, 5'd8, 7'h13), 5'd8, 32'hffff_ffff);
		add_commit(enc_i(12'd1, 5'd8, 3'd0, 5'd9, 7'h13), 5'd9, 32'd0);
		// Store then load of the same words
		add_commit(enc_i(12'd64, 5'd0, 3'd0, 5'd10, 7'h13), 5'd10, 32'd64);
		add_store(enc_s(12'd4, 5'd7, 5'd10), 8'd17, 32'hffff_fff2);
		add_commit(enc_i(12'd4, 5'd10, 3'b010, 5'd11, 7'h03), 5'd11, 32'hffff_fff2);
		add_commit(enc_r(7'h00, 5'd1, 5'd11, 5'd12), 5'd12, 32'hffff_fff7);
		add_store(enc_s(12'd0, 5'd6, 5'd10), 8'd16, 32'h0000_07f8);
		add_commit(enc_i(12'd0, 5'd10, 3'b010, 5'd13, 7'h03), 5'd13, 32'h0000_07f8);
		// Illegal encodings flush the next instruction
		add_except(32'h0000_007f, 4'd2);
		add_flush(enc_i(12'd99, 5'd0, 3'd0, 5'd1, 7'h13));
		add_commit(enc_i(12'd0, 5'd1, 3'd0, 5'd14, 7'h13), 5'd14, 32'd5);
		add_except(enc_r(7'h00, 5'd1, 5'd16, 5'd2), 4'd2);
		add_flush(enc_i(12'd1, 5'd0, 3'd0, 5'd3, 7'h13));
		add_except(enc_i(12'd1, 5'd0, 3'd0, 5'd20, 7'h13), 4'd2);
		add_flush(enc_i(12'd1, 5'd0, 3'd0, 5'd4, 7'h13));
		add_commit(enc_r(7'h00, 5'd4, 5'd3, 5'd15), 5'd15, 32'd9);
		// Misaligned accesses, no L2 traffic
		add_except(enc_i(12'd1, 5'd10, 3'b010, 5'd15, 7'h03), 4'd4);
		add_flush(enc_i(12'd1, 5'd0, 3'd0, 5'd5, 7'h13));
		add_except(enc_s(12'd2, 5'd6, 5'd10), 4'd6);
		add_flush(enc_i(12'd1, 5'd0, 3'd0, 5'd6, 7'h13));
		// x0 stays zero
		add_commit(enc_i(12'd7, 5'd0, 3'd0, 5'd0, 7'h13), 5'd0, 32'd0);
		add_commit(enc_r(7'h00, 5'd0, 5'd0, 5'd15), 5'd15, 32'd0);
		add_commit(enc_r(7'h00, 5'd5, 5'd0, 5'd14), 5'd14, 32'hffff_fff9);
	endtask

	function automatic logic [1:0] next_delay();
		logic [31:0] r;
		r = $random(seed);
		return r[1:0];
	endfunction

	// L2 model with random ready and answer delays
	always @(posedge clk_i) begin
		if (rst_i) begin
			l2_req_rdy_i <= 1'b0;
			l2_ans_i <= '0;
			pending <= 1'b0;
			req_wait <= next_delay();
		end else begin
			if (l2_req_o.valid && l2_req_rdy_i) begin
				req_cnt <= req_cnt + 1;
				l2_req_rdy_i <= 1'b0;
				pending <= 1'b1;
				ans_wait <= next_delay();
				if (l2_req_o.op == MEM_WRITE) begin
					mem[l2_req_o.addr[7:0]] <= l2_req_o.wdata;
				end else begin
					ans_data <= mem[l2_req_o.addr[7:0]];
				end
			end else if (l2_req_o.valid) begin
				if (req_wait == 2'd0) begin
					l2_req_rdy_i <= 1'b1;
				end else begin
					req_wait <= req_wait - 2'd1;
				end
			end
			if (pending && l2_ans_i.valid && l2_ans_rdy_o) begin
				l2_ans_i.valid <= 1'b0;
				pending <= 1'b0;
				req_wait <= next_delay();
			end else if (pending && !l2_ans_i.valid) begin
				if (ans_wait == 2'd0) begin
					l2_ans_i.valid <= 1'b1;
					l2_ans_i.rdata <= ans_data;
				end else begin
					ans_wait <= ans_wait - 2'd1;
				end
			end
		end
	end

	// In-order scoreboard on commits and exceptions
	always @(posedge clk_i) begin
		entry_t e;
		if (!rst_i && (commit_valid_o || except_raised_o)) begin
			if (exp_q.size() == 0) begin
				fail_run("DUT reported a result with no instruction expected");
			end else begin
				e = exp_q.pop_front();
				if (commit_valid_o) begin
					check_equal({30'd0, e.kind}, {30'd0, K_COMMIT}, "commit where kind");
					check_equal({27'd0, commit_rd_o}, {27'd0, e.rd}, "commit rd");
					if (e.chk_mem) begin
						check_equal(commit_data_o, 32'd0, "store commit data");
						check_equal(mem[e.mem_idx], e.data, "stored word");
					end else begin
						check_equal(commit_data_o, e.data, "commit data");
					end
				end else begin
					check_equal({30'd0, e.kind}, {30'd0, K_EXCEPT}, "exception where kind");
					check_equal({28'd0, except_code_o}, {28'd0, e.code}, "exception code");
				end
			end
		end
	end

	// Timeout from the table length
	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			fail_run("timeout: the DUT did not finish the instruction table in time");
		end
	end

	initial begin
		int idx;
		int n_commit;
		int n_l2;
		seed = SEED;
		cycles = 0;
		req_cnt = 0;
		n_commit = 0;
		n_l2 = 0;
		rst_i = 1'b1;
		ins_i = '0;
		ins_valid_i = 1'b0;
		l2_req_rdy_i = 1'b0;
		l2_ans_i = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = i * 32'h9e37_79b9 + 32'h5a5a_0000;
		end
		build_table();
		limit = tbl.size() * 12 + 50;
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;
		@(posedge clk_i);
		// Idle outputs after reset
		check_equal({31'd0, stall_o}, 32'd0, "stall after reset");
		check_equal({31'd0, commit_valid_o}, 32'd0, "commit valid after reset");
		check_equal({31'd0, except_raised_o}, 32'd0, "exception after reset");
		check_equal({31'd0, l2_req_o.valid}, 32'd0, "request valid after reset");
		check_equal({31'd0, l2_ans_rdy_o}, 32'd0, "answer ready after reset");
		check_equal({16'd0, commit_cnt_o}, 32'd0, "commit count after reset");
		idx = 0;
		while (idx < tbl.size()) begin
			ins_i <= tbl[idx].ins;
			ins_valid_i <= 1'b1;
			@(posedge clk_i);
			// Pre-edge stall tells whether this edge accepted
			if (!stall_o) begin
				if (tbl[idx].kind != K_FLUSH) begin
					exp_q.push_back(tbl[idx]);
				end
				if (tbl[idx].kind == K_COMMIT) begin
					n_commit++;
				end
				if (tbl[idx].l2) begin
					n_l2++;
				end
				idx++;
			end
		end
		ins_valid_i <= 1'b0;
		while (exp_q.size() != 0) begin
			@(posedge clk_i);
		end
		repeat (3) @(posedge clk_i);
		check_equal({16'd0, commit_cnt_o}, n_commit, "commit count");
		check_equal(req_cnt, n_l2, "L2 request count");
		check_equal({31'd0, stall_o}, 32'd0, "stall at end");
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
